// File: logic/mmio_map_pkg.sv
package mmio_map_pkg;

  // Region select taken from addr[30:12], one 4 KB window each
  typedef enum logic [18:0] {
    REGION_LEDSW = 19'd0,   // LEDs, switches, buttons
    REGION_UART  = 19'd1    // Serial port
  } region_e;

  // Register select within a region
  localparam int REG_SEL_BIT = 2;

  // LED word layout, register 0 of the LED/SW block
  localparam int LED_R_LSB   = 0;
  localparam int LED_R_WIDTH = 10;
  localparam int LED_G_LSB   = 16;
  localparam int LED_G_WIDTH = 8;

  // Input word layout, register 1 of the LED/SW block
  localparam int SW_LSB  = 0;   // 10 switches
  localparam int BTN_LSB = 16;  // 4 buttons

endpackage

// File: logic/uart_pkg.sv
package uart_pkg;

  // Fixed bit time in core clocks
  localparam logic [15:0] CLKS_PER_BIT = 16'd16;

  // Transmit FSM
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

  // Receive FSM
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,   // Waiting for middle of start bit
    RX_DATA,
    RX_STOP
  } rx_state_e;

  // Status register bits
  localparam int STAT_TX_BUSY    = 0;
  localparam int STAT_RX_VALID   = 1;
  localparam int STAT_RX_OVERRUN = 2;

endpackage

// File: logic/uart_tx.sv
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; (
  input  logic       clkrst_core_clk,
  input  logic       reset,
  input  logic       tx_start,   // Only honored in idle
  input  logic [7:0] tx_data,
  output logic       tx_busy,
  output logic       tx_pin      // Registered serial out
);

  tx_state_e   state;
  logic [15:0] clk_cnt;   // Cycles into current bit
  logic [2:0]  bit_idx;   // Data bit on the line
  logic [7:0]  shift_q;   // LSB first
  logic        bit_done;

  assign bit_done = (clk_cnt == CLKS_PER_BIT - 16'd1);
  assign tx_busy  = (state != TX_IDLE);

  always_ff @(posedge clkrst_core_clk) begin
    if (reset) begin
      state   <= TX_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      tx_pin  <= 1'b1;   // Idle line is mark
    end else begin
      clk_cnt <= (state == TX_IDLE || bit_done) ? 16'd0 : clk_cnt + 16'd1;
      case (state)
        TX_IDLE: begin
          bit_idx <= '0;
          if (tx_start) begin
            state  <= TX_START;
            tx_pin <= 1'b0;   // Start bit
          end
        end
        TX_START: begin
          if (bit_done) begin
            state  <= TX_DATA;
            tx_pin <= shift_q[0];
          end
        end
        TX_DATA: begin
          if (bit_done) begin
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'd7) begin
              state  <= TX_STOP;
              tx_pin <= 1'b1;        // Stop bit
            end else begin
              tx_pin <= shift_q[1];  // Next bit before the shift lands
            end
          end
        end
        TX_STOP: begin
          if (bit_done)
            state <= TX_IDLE;
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Payload shifter
  always_ff @(posedge clkrst_core_clk) begin
    if (state == TX_IDLE && tx_start)
      shift_q <= tx_data;
    else if (state == TX_DATA && bit_done)
      shift_q <= {1'b0, shift_q[7:1]};
  end

  a_idle_mark: assert property (@(posedge clkrst_core_clk) disable iff (reset)
    state == TX_IDLE |-> tx_pin)
    else $error("tx_pin low while transmitter idle");

endmodule

// File: logic/uart_rx.sv
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; (
  input  logic       clkrst_core_clk,
  input  logic       reset,
  input  logic       rx_pin,      // Async serial in
  output logic [7:0] rx_data,     // Valid with rx_strobe
  output logic       rx_strobe    // One cycle per good frame
);

  rx_state_e   state;
  logic        rx_meta;
  logic        rx_sync;
  logic        rx_last;     // For edge detect
  logic        rx_fall;
  logic [15:0] clk_cnt;
  logic [15:0] sample_pt;   // Half bit for start, full bit after
  logic        at_sample;
  logic [2:0]  bit_idx;
  logic [7:0]  shift_q;

  // Synchronizer plus one more flop for the edge
  always_ff @(posedge clkrst_core_clk) begin
    if (reset) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_last <= 1'b1;
    end else begin
      rx_meta <= rx_pin;
      rx_sync <= rx_meta;
      rx_last <= rx_sync;
    end
  end

  assign rx_fall   = rx_last & ~rx_sync;
  assign sample_pt = (state == RX_START) ? (CLKS_PER_BIT >> 1) - 16'd1
                                         : CLKS_PER_BIT - 16'd1;
  assign at_sample = (clk_cnt == sample_pt);

  always_ff @(posedge clkrst_core_clk) begin
    if (reset) begin
      state     <= RX_IDLE;
      clk_cnt   <= '0;
      bit_idx   <= '0;
      rx_strobe <= 1'b0;
    end else begin
      rx_strobe <= 1'b0;
      clk_cnt   <= (state == RX_IDLE || at_sample) ? 16'd0 : clk_cnt + 16'd1;
      case (state)
        RX_IDLE: begin
          bit_idx <= '0;
          if (rx_fall)
            state <= RX_START;
        end
        RX_START: begin
          // Still low at half bit, else it was a glitch
          if (at_sample)
            state <= rx_sync ? RX_IDLE : RX_DATA;
        end
        RX_DATA: begin
          if (at_sample) begin
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'd7)
              state <= RX_STOP;
          end
        end
        RX_STOP: begin
          if (at_sample) begin
            state     <= RX_IDLE;
            rx_strobe <= rx_sync;   // Framing error drops the byte
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // Mid-bit samples enter at the top, LSB ends at bit 0
  always_ff @(posedge clkrst_core_clk) begin
    if (state == RX_DATA && at_sample)
      shift_q <= {rx_sync, shift_q[7:1]};
  end

  assign rx_data = shift_q;   // Stable until next frame's data bits

  a_strobe_pulse: assert property (@(posedge clkrst_core_clk) disable iff (reset)
    rx_strobe |=> !rx_strobe)
    else $error("rx_strobe held longer than one cycle");

endmodule

// File: logic/uart.sv
`timescale 1ns/1ps

module uart import uart_pkg::*; (
  input  logic        clkrst_core_clk,
  input  logic        reset,
  input  logic        reg_sel,     // 0 data, 1 status
  input  logic        write_en,    // Byte 0 strobe, region already decoded
  input  logic [31:0] write_val,
  output logic [31:0] read_val,
  output logic        tx_pin,
  input  logic        rx_pin
);

  logic       tx_start;
  logic [7:0] tx_data;
  logic       tx_busy;
  logic [7:0] rx_data;
  logic       rx_strobe;
  logic [7:0] rx_buf;        // Last received byte
  logic       rx_valid;
  logic       rx_overrun;
  logic       clr_valid;
  logic       clr_overrun;
  logic [2:0] status;

  // Data write kicks off a frame; dropped while busy
  assign tx_start = write_en & ~reg_sel & ~tx_busy;
  assign tx_data  = write_val[7:0];

  // Write-one-to-clear on status
  assign clr_valid   = write_en & reg_sel & write_val[STAT_RX_VALID];
  assign clr_overrun = write_en & reg_sel & write_val[STAT_RX_OVERRUN];

  always_ff @(posedge clkrst_core_clk) begin
    if (reset) begin
      rx_buf     <= '0;
      rx_valid   <= 1'b0;
      rx_overrun <= 1'b0;
    end else begin
      if (clr_valid)
        rx_valid <= 1'b0;
      if (clr_overrun)
        rx_overrun <= 1'b0;
      // New byte wins over a clear in the same cycle
      if (rx_strobe) begin
        rx_buf   <= rx_data;   // Overwrites unread byte
        rx_valid <= 1'b1;
        if (rx_valid && !clr_valid)
          rx_overrun <= 1'b1;  // Previous byte lost
      end
    end
  end

  always_comb begin
    status = '0;
    status[STAT_TX_BUSY]    = tx_busy;
    status[STAT_RX_VALID]   = rx_valid;
    status[STAT_RX_OVERRUN] = rx_overrun;
  end

  assign read_val = reg_sel ? {29'b0, status} : {24'b0, rx_buf};

  uart_tx i_uart_tx (
    .clkrst_core_clk (clkrst_core_clk),
    .reset           (reset),
    .tx_start        (tx_start),
    .tx_data         (tx_data),
    .tx_busy         (tx_busy),
    .tx_pin          (tx_pin)
  );

  uart_rx i_uart_rx (
    .clkrst_core_clk (clkrst_core_clk),
    .reset           (reset),
    .rx_pin          (rx_pin),
    .rx_data         (rx_data),
    .rx_strobe       (rx_strobe)
  );

  // Start only from idle, and the transmitter must accept it
  a_tx_start_idle: assert property (@(posedge clkrst_core_clk) disable iff (reset)
    tx_start |-> !tx_busy ##1 tx_busy)
    else $error("tx_start issued while busy or not taken");

endmodule

// File: logic/soc_ledsw.sv
`timescale 1ns/1ps

module soc_ledsw import mmio_map_pkg::*; (
  input  logic        clkrst_core_clk,
  input  logic        reset,
  input  logic        reg_sel,       // 0 LED word, 1 input word
  input  logic [31:0] data_in,
  input  logic [31:0] write_mask,    // Already zero outside this region
  output logic [31:0] data_out,
  output logic [9:0]  ext_led_r,
  output logic [7:0]  ext_led_g,
  input  logic [9:0]  ext_switches,
  input  logic [3:0]  ext_buttons
);

  logic [LED_R_WIDTH-1:0] led_r_q;
  logic [LED_G_WIDTH-1:0] led_g_q;
  logic [LED_R_WIDTH-1:0] r_mask;
  logic [LED_G_WIDTH-1:0] g_mask;
  logic [13:0]            in_meta;   // Buttons over switches
  logic [13:0]            in_sync;
  logic [31:0]            led_word;
  logic [31:0]            in_word;

  assign r_mask = write_mask[LED_R_LSB +: LED_R_WIDTH];
  assign g_mask = write_mask[LED_G_LSB +: LED_G_WIDTH];

  // LED register, bitwise merge under mask
  always_ff @(posedge clkrst_core_clk) begin
    if (reset) begin
      led_r_q <= '0;
      led_g_q <= '0;
    end else if (!reg_sel) begin   // Input word is read only
      led_r_q <= (led_r_q & ~r_mask) | (data_in[LED_R_LSB +: LED_R_WIDTH] & r_mask);
      led_g_q <= (led_g_q & ~g_mask) | (data_in[LED_G_LSB +: LED_G_WIDTH] & g_mask);
    end
  end

  // Two-flop sync on async board inputs
  always_ff @(posedge clkrst_core_clk) begin
    if (reset) begin
      in_meta <= '0;
      in_sync <= '0;
    end else begin
      in_meta <= {ext_buttons, ext_switches};
      in_sync <= in_meta;
    end
  end

  // Read words, unused bits zero
  always_comb begin
    led_word = '0;
    led_word[LED_R_LSB +: LED_R_WIDTH] = led_r_q;
    led_word[LED_G_LSB +: LED_G_WIDTH] = led_g_q;
    in_word = '0;
    in_word[SW_LSB +: 10] = in_sync[9:0];
    in_word[BTN_LSB +: 4] = in_sync[13:10];
  end

  assign data_out  = reg_sel ? in_word : led_word;
  assign ext_led_r = led_r_q;
  assign ext_led_g = led_g_q;

endmodule

// File: logic/soc_mmio.sv
`timescale 1ns/1ps

module soc_mmio import mmio_map_pkg::*; (
  input  logic        clkrst_core_clk,
  input  logic        reset,
  input  logic [31:0] data_in,
  input  logic [30:2] addr,       // Word address
  input  logic [3:0]  wren,       // Byte write enables
  output logic [31:0] data_out,   // Combinational read data
  output logic [7:0]  ext_led_g,
  output logic [9:0]  ext_led_r,
  input  logic [9:0]  ext_switches,
  input  logic [3:0]  ext_buttons,
  input  logic        ext_uart_rx,
  output logic        ext_uart_tx
);

  region_e     region;
  logic        is_ledsw;
  logic        is_uart;
  logic        reg_sel;
  logic [31:0] byte_mask;
  logic [31:0] ledsw_mask;
  logic        uart_write_en;
  logic [31:0] ledsw_data_out;
  logic [31:0] uart_read_val;

  assign region  = region_e'(addr[30:12]);
  assign reg_sel = addr[REG_SEL_BIT];

  // Byte enables spread to a bit mask
  assign byte_mask = {{8{wren[3]}}, {8{wren[2]}}, {8{wren[1]}}, {8{wren[0]}}};

  // Region decode and read mux
  always_comb begin
    is_ledsw = 1'b0;
    is_uart  = 1'b0;
    data_out = '0;               // Unmapped reads as zero
    case (region)
      REGION_LEDSW: begin
        is_ledsw = 1'b1;
        data_out = ledsw_data_out;
      end
      REGION_UART: begin
        is_uart  = 1'b1;
        data_out = uart_read_val;
      end
      default: ;
    endcase
  end

  assign ledsw_mask    = is_ledsw ? byte_mask : 32'h0;   // No writes outside region
  assign uart_write_en = is_uart & wren[0];              // UART regs are byte wide

  soc_ledsw i_soc_ledsw (
    .clkrst_core_clk (clkrst_core_clk),
    .reset           (reset),
    .reg_sel         (reg_sel),
    .data_in         (data_in),
    .write_mask      (ledsw_mask),
    .data_out        (ledsw_data_out),
    .ext_led_r       (ext_led_r),
    .ext_led_g       (ext_led_g),
    .ext_switches    (ext_switches),
    .ext_buttons     (ext_buttons)
  );

  uart i_uart (
    .clkrst_core_clk (clkrst_core_clk),
    .reset           (reset),
    .reg_sel         (reg_sel),
    .write_en        (uart_write_en),
    .write_val       (data_in),
    .read_val        (uart_read_val),
    .tx_pin          (ext_uart_tx),
    .rx_pin          (ext_uart_rx)
  );

  // Every block must return clean data once out of reset
  a_data_out_known: assert property (@(posedge clkrst_core_clk) disable iff (reset)
    !$isunknown(data_out))
    else $error("data_out carries X for addr %h", addr);

endmodule

// File: verif/soc_mmio_tb.sv
`timescale 1ns/1ps

module soc_mmio_tb import mmio_map_pkg::*, uart_pkg::*; ();

  logic        clkrst_core_clk;
  logic        reset;
  logic [31:0] data_in;
  logic [30:2] addr;
  logic [3:0]  wren;
  logic [31:0] data_out;
  logic [7:0]  ext_led_g;
  logic [9:0]  ext_led_r;
  logic [9:0]  ext_switches;
  logic [3:0]  ext_buttons;
  logic        ext_uart_rx;
  logic        ext_uart_tx;
  logic        loopback;       // Ties serial out back to serial in
  int          value_errors;
  int          timeout_errors;

  assign ext_uart_rx = loopback ? ext_uart_tx : 1'b1;   // Idle mark when open

  soc_mmio i_soc_mmio (.*);

  initial begin
    clkrst_core_clk = 1'b0;
    forever #50 clkrst_core_clk = ~clkrst_core_clk;
  end

  // Word address from region value and register select
  function automatic logic [30:2] make_addr(input logic [18:0] region_val, input logic sel);
    logic [30:2] a;
    a = '0;
    a[30:12] = region_val;
    a[REG_SEL_BIT] = sel;
    return a;
  endfunction

  // Model LED word after a byte-masked write
  function automatic logic [31:0] exp_led(input logic [31:0] old, input logic [31:0] val,
                                          input logic [3:0] be);
    logic [31:0] mask;
    logic [31:0] fields;
    mask   = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    fields = '0;
    fields[LED_R_LSB +: LED_R_WIDTH] = '1;
    fields[LED_G_LSB +: LED_G_WIDTH] = '1;
    return ((old & ~mask) | (val & mask)) & fields;   // Unused bits read zero
  endfunction

  function automatic logic [31:0] exp_inputs(input logic [9:0] sw, input logic [3:0] btn);
    logic [31:0] w;
    w = '0;
    w[SW_LSB +: 10] = sw;
    w[BTN_LSB +: 4] = btn;
    return w;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      value_errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  // Called 1 ns after an edge; write lands on the next edge
  task automatic bus_write(input logic [30:2] a, input logic [31:0] val, input logic [3:0] be);
    addr    = a;
    data_in = val;
    wren    = be;
    @(posedge clkrst_core_clk);
    #1 wren = 4'h0;
  endtask

  task automatic bus_read(input logic [30:2] a, output logic [31:0] val);
    addr = a;
    wren = 4'h0;
    #10 val = data_out;   // Combinational, settled well before the edge
    @(posedge clkrst_core_clk);
    #1;
  endtask

  task automatic wait_status(input int bit_pos, input logic level, input int limit,
                             input string what);
    logic [31:0] val;
    int          n;
    bit          done;
    n    = 0;
    done = 1'b0;
    while (!done && n < limit) begin
      bus_read(make_addr(REGION_UART, 1'b1), val);
      done = (val[bit_pos] === level);
      n++;
    end
    if (!done) begin
      timeout_errors++;
      $display("Timeout while waiting for %s: status bit %0d never reached %0b in %0d cycles",
               what, bit_pos, level, limit);
    end
  endtask

  initial begin
    logic [31:0] led_model;
    logic [31:0] val;
    logic [31:0] rd;
    logic [3:0]  be;
    logic [7:0]  byte_a;
    logic [7:0]  byte_b;
    int unsigned seed_val;
    seed_val       = $urandom(76);
    value_errors   = 0;
    timeout_errors = 0;
    reset = 1'b1;
    data_in = '0;
    addr = '0;
    wren = 4'h0;
    ext_switches = '0;
    ext_buttons = '0;
    loopback = 1'b0;
    led_model = '0;
    repeat (3) @(posedge clkrst_core_clk);
    #1 reset = 1'b0;

    // Reset state
    check_value("reset led_r", 32'h0, ext_led_r);
    check_value("reset led_g", 32'h0, ext_led_g);
    check_value("reset uart_tx", 32'h1, ext_uart_tx);
    bus_read(make_addr(REGION_UART, 1'b1), rd);
    check_value("reset status", 32'h0, rd);

    // LED writes under random byte enables
    for (int i = 0; i < 20; i++) begin
      val = $urandom;
      be  = $urandom_range(15, 0);
      bus_write(make_addr(REGION_LEDSW, 1'b0), val, be);
      led_model = exp_led(led_model, val, be);
      check_value("led_r out", led_model[LED_R_LSB +: LED_R_WIDTH], ext_led_r);
      check_value("led_g out", led_model[LED_G_LSB +: LED_G_WIDTH], ext_led_g);
      bus_read(make_addr(REGION_LEDSW, 1'b0), rd);
      check_value("led readback", led_model, rd);
    end

    // Switches and buttons through the synchronizer
    for (int i = 0; i < 10; i++) begin
      ext_switches = $urandom_range(1023, 0);
      ext_buttons  = $urandom_range(15, 0);
      repeat (2) @(posedge clkrst_core_clk);
      #1 bus_read(make_addr(REGION_LEDSW, 1'b1), rd);
      check_value("inputs", exp_inputs(ext_switches, ext_buttons), rd);
    end

    // Single byte over loopback, second write dropped
    loopback = 1'b1;
    byte_a = $urandom_range(255, 0);
    bus_write(make_addr(REGION_UART, 1'b0), {24'h0, byte_a}, 4'h1);
    bus_read(make_addr(REGION_UART, 1'b1), rd);
    check_value("busy after write", 32'h1, rd[STAT_TX_BUSY]);
    bus_write(make_addr(REGION_UART, 1'b0), {24'h0, ~byte_a}, 4'h1);   // Tx still busy
    wait_status(STAT_RX_VALID, 1'b1, 15 * CLKS_PER_BIT, "rx valid");
    bus_read(make_addr(REGION_UART, 1'b0), rd);
    check_value("rx byte", {24'h0, byte_a}, rd);
    wait_status(STAT_TX_BUSY, 1'b0, 15 * CLKS_PER_BIT, "tx idle");
    bus_read(make_addr(REGION_UART, 1'b1), rd);   // One byte only, no second frame
    check_value("dropped write", 32'h1 << STAT_RX_VALID, rd);
    bus_write(make_addr(REGION_UART, 1'b1), 32'h6, 4'h1);

    // Two bytes without clearing valid
    byte_a = $urandom_range(255, 0);
    byte_b = $urandom_range(255, 0);
    bus_write(make_addr(REGION_UART, 1'b0), {24'h0, byte_a}, 4'h1);
    wait_status(STAT_TX_BUSY, 1'b0, 15 * CLKS_PER_BIT, "first frame done");
    bus_write(make_addr(REGION_UART, 1'b0), {24'h0, byte_b}, 4'h1);
    wait_status(STAT_RX_OVERRUN, 1'b1, 15 * CLKS_PER_BIT, "rx overrun");
    wait_status(STAT_TX_BUSY, 1'b0, 15 * CLKS_PER_BIT, "second frame done");
    bus_read(make_addr(REGION_UART, 1'b1), rd);
    check_value("overrun status", (32'h1 << STAT_RX_VALID) | (32'h1 << STAT_RX_OVERRUN), rd);
    bus_read(make_addr(REGION_UART, 1'b0), rd);
    check_value("overrun byte", {24'h0, byte_b}, rd);
    bus_write(make_addr(REGION_UART, 1'b1), 32'h6, 4'h1);
    bus_read(make_addr(REGION_UART, 1'b1), rd);
    check_value("status cleared", 32'h0, rd);

    // Unmapped region 2
    bus_read(make_addr(19'd2, 1'b0), rd);
    check_value("unmapped read", 32'h0, rd);
    bus_write(make_addr(19'd2, 1'b0), 32'hffff_ffff, 4'hf);
    check_value("unmapped led_r", led_model[LED_R_LSB +: LED_R_WIDTH], ext_led_r);
    check_value("unmapped led_g", led_model[LED_G_LSB +: LED_G_WIDTH], ext_led_g);
    bus_read(make_addr(REGION_UART, 1'b1), rd);
    check_value("unmapped status", 32'h0, rd);

    $display("Errors: %0d value, %0d timeout", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: build.f
logic/mmio_map_pkg.sv
logic/uart_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart.sv
logic/soc_ledsw.sv
logic/soc_mmio.sv
verif/soc_mmio_tb.sv

// File: Bender.yml
package:
  name: soc_mmio

sources:
  - logic/mmio_map_pkg.sv
  - logic/uart_pkg.sv
  - logic/uart_tx.sv
  - logic/uart_rx.sv
  - logic/uart.sv
  - logic/soc_ledsw.sv
  - logic/soc_mmio.sv
  - target: test
    files:
      - verif/soc_mmio_tb.sv
